// ==== testbench/testdata_pixels.hex ====
// One word per active pixel in raster order, 13 hex digits:
// mode bit (1 digit), input RGB (6 digits), expected output RGB (6 digits)
1000000101010
0ffffffffffff
1ffffffeaeaea
0804020804020
18040207e472b
1c0c8f0b4bbdd
0123456123456
1ff0000ea1010
100ff0010ea10
10000ff1010ea
0aa5532aa5532
1aa5532a1593b
11064011e6611
0010203010203
1f02080dd2b7e
15540c85947bb
0c0ffeec0ffee
18080807e7e7e
1643210663b1e
0deadbedeadbe
1c8aa01bba111
120f0552bdd59
000ff8000ff80
1405500475910

// ==== files.f ====
common/hdmi_out_pkg.sv
source/video_timing_gen.sv
source/color_range_conv.sv
source/hdmi_out_stage.sv
source/hdmi_out_top.sv
testbench/hdmi_out_props.sv
testbench/tb_hdmi_out.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the HDMI output testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_hdmi_out -f files.f || exit 1
out=$(./obj_dir/Vtb_hdmi_out)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== testbench/tb_hdmi_out.sv ====
/*
 * Testbench for the HDMI output top level
 * Runs two frames of a small raster. Active pixels come from the data
 * file, blanking gets random data. Syncs, data enable and pixels are
 * checked against a raster model and the range rule.
 */

`timescale 1ns/1ps

module tb_hdmi_out;

  import hdmi_out_pkg::*;

  // Small raster, 10 clocks per line, 9 lines per frame
  localparam int H_SYNC   = 2;
  localparam int H_BACK   = 2;
  localparam int H_ACTIVE = 4;
  localparam int H_FRONT  = 2;
  localparam int V_SYNC   = 1;
  localparam int V_BACK   = 1;
  localparam int V_ACTIVE = 6;
  localparam int V_FRONT  = 1;
  localparam int H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
  localparam int FRAME    = H_TOTAL * (V_SYNC + V_BACK + V_ACTIVE + V_FRONT);
  localparam int NPIX     = H_ACTIVE * V_ACTIVE;
  localparam int RST_CYC  = 10;
  // Register stages from vd_i to the pins
  localparam int OUT_LAT  = 3;
  localparam int RUN_POS  = 2 * FRAME;
  localparam int TIMEOUT  = 3 * FRAME + RST_CYC;

  logic   HDMI_CLK_w = 1'b0;
  logic   HDMI_nRST_w;
  logic   limited_range_i;
  pixel_t vd_i;
  logic   hsync_o;
  logic   vsync_o;
  logic   de_o;
  pixel_t vd_o;

  // Mode in [48], input pixel in [47:24], expected pixel in [23:0]
  logic [51:0] data_mem [NPIX];
  // What was driven at each raster position
  pixel_t      drv_pix  [RUN_POS];
  logic        drv_mode [RUN_POS];
  integer      seed = 32'h241e;
  int          cyc = 0;
  int          err [6];
  int          chk [6];
  string       test_name [6] = '{"after reset", "hsync", "vsync", "de count",
                                 "pixel values", "blanking"};
  // Pulse shape tracking on the pins
  int          hs_rise = -1;
  int          hs_width = 0;
  int          vs_rise = -1;
  int          vs_cnt = 0;
  int          de_cnt = 0;
  int          de_runs = 0;
  logic        prev_hs = 1'b0;
  logic        prev_vs = 1'b0;
  logic        prev_de = 1'b0;

  hdmi_out_top #(
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT)
  ) UUT (
    .HDMI_CLK_w      (HDMI_CLK_w),
    .HDMI_nRST_w     (HDMI_nRST_w),
    .limited_range_i (limited_range_i),
    .vd_i            (vd_i),
    .hsync_o         (hsync_o),
    .vsync_o         (vsync_o),
    .de_o            (de_o),
    .vd_o            (vd_o)
  );

  always #10 HDMI_CLK_w = ~HDMI_CLK_w;

  // Hard stop if the run never reaches its end
  always @(posedge HDMI_CLK_w) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the run did not finish", cyc);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Full to limited mapping of one channel
  function automatic color_t range_map_chan(color_t x);
    int v;
    v = 16 + ((int'(x) * 219 + 128) >>> 8);
    return color_t'(v);
  endfunction

  function automatic pixel_t expect_pix(pixel_t p, logic lim);
    if (!lim)
      return p;
    return {range_map_chan(p[23:16]), range_map_chan(p[15:8]), range_map_chan(p[7:0])};
  endfunction

  // Index into the frame's active pixels, -1 in blanking
  function automatic int active_idx(int p);
    int h;
    int l;
    h = p % H_TOTAL;
    l = (p % FRAME) / H_TOTAL;
    if (h < H_SYNC + H_BACK || h >= H_SYNC + H_BACK + H_ACTIVE)
      return -1;
    if (l < V_SYNC + V_BACK || l >= V_SYNC + V_BACK + V_ACTIVE)
      return -1;
    return (l - V_SYNC - V_BACK) * H_ACTIVE + h - H_SYNC - H_BACK;
  endfunction

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic mismatch(input int t, input string sig, input logic [23:0] got,
                          input logic [23:0] exp);
    $display("[ERROR] cycle %0d %s got %0h exp %0h", cyc, sig, got, exp);
    err[t]++;
  endtask

  task automatic fail_note(input int t, input string msg);
    $display("Error at cycle %0d: %s", cyc, msg);
    err[t]++;
  endtask

  task automatic report_test(input int t);
    $display("Test %0d %s: %s, %0d checks, %0d errors", t, test_name[t],
             (err[t] == 0) ? "ok" : "FAILED", chk[t], err[t]);
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  // File pixel in active area, random data elsewhere
  task automatic drive_pos(input int k);
    int          idx;
    logic [51:0] w;
    logic [31:0] rnd;
    idx = (k < RUN_POS) ? active_idx(k) : -1;
    if (idx >= 0) begin
      w = data_mem[idx];
      vd_i = w[47:24];
      // Second frame flips every mode bit
      limited_range_i = w[48] ^ (k >= FRAME);
    end else begin
      rnd = $random(seed);
      vd_i = rnd[23:0];
      limited_range_i = rnd[31];
    end
    if (k < RUN_POS) begin
      drv_pix[k] = vd_i;
      drv_mode[k] = limited_range_i;
    end
  endtask

  // Pins while reset is on or the pipeline is still filling
  task automatic check_idle();
    chk[0]++;
    if (hsync_o !== 1'b0)
      mismatch(0, "hsync_o", 24'(hsync_o), 24'h0);
    if (vsync_o !== 1'b0)
      mismatch(0, "vsync_o", 24'(vsync_o), 24'h0);
    if (de_o !== 1'b0)
      mismatch(0, "de_o", 24'(de_o), 24'h0);
    if (vd_o !== '0)
      mismatch(0, "vd_o", vd_o, 24'h0);
  endtask

  task automatic check_outputs(input int p);
    int     idx;
    logic   ede;
    pixel_t epix;
    idx = active_idx(p);
    ede = (idx >= 0);
    chk[1]++;
    chk[2]++;
    chk[3]++;
    if (hsync_o !== ((p % H_TOTAL) < H_SYNC))
      mismatch(1, "hsync_o", 24'(hsync_o), 24'((p % H_TOTAL) < H_SYNC));
    if (vsync_o !== (((p % FRAME) / H_TOTAL) < V_SYNC))
      mismatch(2, "vsync_o", 24'(vsync_o), 24'(((p % FRAME) / H_TOTAL) < V_SYNC));
    if (de_o !== ede)
      mismatch(3, "de_o", 24'(de_o), 24'(ede));
    if (de_o && ede) begin
      chk[4]++;
      epix = expect_pix(drv_pix[p], drv_mode[p]);
      // First frame also holds the file's own expected column
      if (p < FRAME && data_mem[idx][23:0] !== epix)
        fail_note(4, $sformatf("file expected column disagrees with range rule, pixel %0d", idx));
      if (vd_o !== epix)
        mismatch(4, "vd_o", vd_o, epix);
    end
    if (!de_o) begin
      chk[5]++;
      if (vd_o !== '0)
        mismatch(5, "vd_o", vd_o, 24'h0);
    end
    // hsync width and period
    if (hsync_o && !prev_hs) begin
      if (hs_rise >= 0 && p - hs_rise != H_TOTAL)
        fail_note(1, $sformatf("hsync period %0d clocks", p - hs_rise));
      hs_rise = p;
    end
    if (!hsync_o && prev_hs) begin
      if (hs_width != H_SYNC)
        fail_note(1, $sformatf("hsync pulse %0d clocks wide", hs_width));
      hs_width = 0;
    end
    hs_width += int'(hsync_o);
    // Frame period from vsync rises
    if (vsync_o && !prev_vs) begin
      if (vs_rise >= 0 && p - vs_rise != FRAME)
        fail_note(2, $sformatf("frame period %0d clocks", p - vs_rise));
      vs_rise = p;
    end
    vs_cnt += int'(vsync_o);
    de_cnt += int'(de_o);
    if (de_o && !prev_de)
      de_runs++;
    prev_hs = hsync_o;
    prev_vs = vsync_o;
    prev_de = de_o;
    // Per frame totals
    if (p % FRAME == FRAME - 1) begin
      if (vs_cnt != H_TOTAL)
        fail_note(2, $sformatf("vsync high %0d clocks in a frame", vs_cnt));
      if (de_cnt != NPIX || de_runs != V_ACTIVE)
        fail_note(3, $sformatf("de high %0d clocks in %0d runs", de_cnt, de_runs));
      vs_cnt = 0;
      de_cnt = 0;
      de_runs = 0;
    end
  endtask

  initial begin
    int k;
    int nchk;
    int nerr;
    HDMI_nRST_w = 1'b0;
    limited_range_i = 1'b0;
    vd_i = '0;
    for (int t = 0; t < 6; t++) begin
      err[t] = 0;
      chk[t] = 0;
    end
    $readmemh("testbench/testdata_pixels.hex", data_mem);
    repeat (RST_CYC) begin
      @(negedge HDMI_CLK_w);
      check_idle();
    end
    // Release on a falling edge, next rising edge is raster clock 0
    for (k = 0; k < RUN_POS + OUT_LAT; k++) begin
      if (k > 0)
        @(negedge HDMI_CLK_w);
      if (k < OUT_LAT)
        check_idle();
      else
        check_outputs(k - OUT_LAT);
      if (k == OUT_LAT - 1)
        report_test(0);
      HDMI_nRST_w = 1'b1;
      drive_pos(k);
    end
    nchk = 0;
    nerr = 0;
    for (int t = 0; t < 6; t++) begin
      if (t > 0)
        report_test(t);
      nchk += chk[t];
      nerr += err[t];
    end
    $display("Tests 6, checks %0d, errors %0d", nchk, nerr);
    if (nerr == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== testbench/hdmi_out_props.sv ====
/*
 * Output timing properties
 * Bound into the HDMI output top level to watch the pins
 */

`timescale 1ns/1ps

module hdmi_out_props (
  input logic                 HDMI_CLK_w,
  input logic                 HDMI_nRST_w,
  input logic                 hsync_o,
  input logic                 vsync_o,
  input logic                 de_o,
  input hdmi_out_pkg::pixel_t vd_o
);

  // Active video only opens outside both sync pulses
  de_rise_in_blank: assert property (
    @(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    $rose(de_o) |-> (!hsync_o && !vsync_o)
  ) else $error("de_o rose while hsync_o or vsync_o was high");

  // Black on the pins outside data enable
  blank_when_idle: assert property (
    @(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !de_o |-> (vd_o == '0)
  ) else $error("vd_o not zero while de_o low");

endmodule

bind hdmi_out_top hdmi_out_props props_u (
  .HDMI_CLK_w  (HDMI_CLK_w),
  .HDMI_nRST_w (HDMI_nRST_w),
  .hsync_o     (hsync_o),
  .vsync_o     (vsync_o),
  .de_o        (de_o),
  .vd_o        (vd_o)
);

// ==== source/hdmi_out_top.sv ====
/*
 * HDMI output top level
 * Raster timing generator and color range converter side by side,
 * joined in the registered output stage. Timing values are set here
 * and passed down to the generator.
 */

`timescale 1ns/1ps

module hdmi_out_top #(
  parameter int H_SYNC   = 44,
  parameter int H_BACK   = 148,
  parameter int H_ACTIVE = 1920,
  parameter int H_FRONT  = 88,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 36,
  parameter int V_ACTIVE = 1080,
  parameter int V_FRONT  = 4
) (
  input  logic                  HDMI_CLK_w,
  input  logic                  HDMI_nRST_w,
  input  logic                  limited_range_i,
  input  hdmi_out_pkg::pixel_t  vd_i,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  de_o,
  output hdmi_out_pkg::pixel_t  vd_o
);

  import hdmi_out_pkg::*;

  // Delayed syncs from the generator
  sync_t  tim_sync;
  // Pixel after range mapping
  pixel_t conv_pix;

  //////////////////////////////
  // Timing path
  //////////////////////////////

  video_timing_gen #(
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT)
  ) timing_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w),
    .sync_o      (tim_sync)
  );

  //////////////////////////////
  // Pixel path
  //////////////////////////////

  color_range_conv conv_u (
    .HDMI_CLK_w      (HDMI_CLK_w),
    .HDMI_nRST_w     (HDMI_nRST_w),
    .limited_range_i (limited_range_i),
    .pix_i           (vd_i),
    .pix_o           (conv_pix)
  );

  // Both paths meet here, one more clock to the pins
  hdmi_out_stage out_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w),
    .sync_i      (tim_sync),
    .pix_i       (conv_pix),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .de_o        (de_o),
    .vd_o        (vd_o)
  );

endmodule

// ==== source/hdmi_out_stage.sv ====
/*
 * HDMI output stage
 * Registers sync, data enable and pixel data onto the pins and
 * forces the pixel to black outside the active area
 */

`timescale 1ns/1ps

module hdmi_out_stage (
  input  logic                  HDMI_CLK_w,
  input  logic                  HDMI_nRST_w,
  input  hdmi_out_pkg::sync_t   sync_i,
  input  hdmi_out_pkg::pixel_t  pix_i,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  de_o,
  output hdmi_out_pkg::pixel_t  vd_o
);

  //////////////////////////////
  // Output registers
  //////////////////////////////

  // Pins come straight from flops
  // All low and black until the pipeline has filled
  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vd_o    <= '0;
    end else begin
      hsync_o <= sync_i.hsync;
      vsync_o <= sync_i.vsync;
      de_o    <= sync_i.de;
      // Blank outside data enable
      // Whatever arrives in the porches never reaches the pins
      if (sync_i.de)
        vd_o <= pix_i;
      else
        vd_o <= '0;
    end
  end

endmodule

// ==== source/color_range_conv.sv ====
/*
 * Color range converter
 * Maps each 8 bit channel from full range to limited range
 * (16 to 235) as 16 + ((x * 219 + 128) >> 8), or passes the
 * pixel through untouched. Fixed latency of two clocks.
 */

`timescale 1ns/1ps

module color_range_conv (
  input  logic                  HDMI_CLK_w,
  input  logic                  HDMI_nRST_w,
  input  logic                  limited_range_i,
  input  hdmi_out_pkg::pixel_t  pix_i,
  output hdmi_out_pkg::pixel_t  pix_o
);

  import hdmi_out_pkg::*;

  // Product of one channel and the gain, max 255 * 219 + 128 fits
  typedef logic [15:0] prod_t;

  localparam prod_t  LIM_GAIN   = prod_t'(219);
  localparam prod_t  LIM_ROUND  = prod_t'(128);
  localparam color_t LIM_OFFSET = color_t'(16);

  logic   mode_q;
  prod_t  prod_q [3];
  pixel_t pix_q;
  pixel_t lim_pix;

  // Round, drop the fraction, add the black level
  function automatic color_t limit_chan(prod_t prod);
    prod_t rnd;
    rnd = prod + LIM_ROUND;
    return rnd[15:8] + LIM_OFFSET;
  endfunction

  //////////////////////////////
  // Stage 1
  //////////////////////////////

  // Mode bit travels with its pixel
  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w)
      mode_q <= 1'b0;
    else
      mode_q <= limited_range_i;
  end

  // Per channel products, raw pixel kept for bypass
  always_ff @(posedge HDMI_CLK_w) begin
    for (int c = 0; c < 3; c++) begin
      prod_q[c] <= prod_t'(pix_i[8*c +: 8]) * LIM_GAIN;
    end
    pix_q <= pix_i;
  end

  //////////////////////////////
  // Stage 2
  //////////////////////////////

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      lim_pix[8*c +: 8] = limit_chan(prod_q[c]);
    end
  end

  // Limited result or the delayed input
  always_ff @(posedge HDMI_CLK_w) begin
    pix_o <= mode_q ? lim_pix : pix_q;
  end

endmodule

// ==== source/video_timing_gen.sv ====
/*
 * Raster timing generator
 * Walks each line through sync, back porch, active and front porch,
 * counts lines per frame and derives hsync, vsync and data enable.
 * The sync bundle is delayed to line up with the pixel path.
 */

`timescale 1ns/1ps

module video_timing_gen #(
  parameter int H_SYNC   = 44,
  parameter int H_BACK   = 148,
  parameter int H_ACTIVE = 1920,
  parameter int H_FRONT  = 88,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 36,
  parameter int V_ACTIVE = 1080,
  parameter int V_FRONT  = 4
) (
  input  logic                 HDMI_CLK_w,
  input  logic                 HDMI_nRST_w,
  output hdmi_out_pkg::sync_t  sync_o
);

  import hdmi_out_pkg::*;

  // Frame geometry in lines
  localparam int V_TOTAL     = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
  localparam int V_ACT_START = V_SYNC + V_BACK;
  localparam int V_ACT_END   = V_ACT_START + V_ACTIVE;

  hphase_e phase_q;
  hphase_e phase_nxt;
  hcnt_t   pcnt_q;
  hcnt_t   phase_last;
  vcnt_t   line_q;
  logic    phase_end;
  logic    line_end;
  sync_t   raw_sync;
  sync_t   dly_q [PIX_LAT];

  //////////////////////////////
  // Horizontal FSM
  //////////////////////////////

  // Last count of the current phase and the phase that follows
  always_comb begin
    unique case (phase_q)
      HP_SYNC: begin
        phase_last = hcnt_t'(H_SYNC - 1);
        phase_nxt  = HP_BACK;
      end
      HP_BACK: begin
        phase_last = hcnt_t'(H_BACK - 1);
        phase_nxt  = HP_ACTIVE;
      end
      HP_ACTIVE: begin
        phase_last = hcnt_t'(H_ACTIVE - 1);
        phase_nxt  = HP_FRONT;
      end
      default: begin
        phase_last = hcnt_t'(H_FRONT - 1);
        phase_nxt  = HP_SYNC;
      end
    endcase
  end

  assign phase_end = (pcnt_q == phase_last);
  // Last clock of the front porch closes the line
  assign line_end  = phase_end && (phase_q == HP_FRONT);

  // Reset lands on clock 0 of line 0
  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      phase_q <= HP_SYNC;
      pcnt_q  <= '0;
    end else if (phase_end) begin
      phase_q <= phase_nxt;
      pcnt_q  <= '0;
    end else begin
      pcnt_q  <= pcnt_q + hcnt_t'(1);
    end
  end

  //////////////////////////////
  // Line counter
  //////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      line_q <= '0;
    end else if (line_end) begin
      // Wrap at end of frame
      if (line_q == vcnt_t'(V_TOTAL - 1))
        line_q <= '0;
      else
        line_q <= line_q + vcnt_t'(1);
    end
  end

  //////////////////////////////
  // Sync decode and delay
  //////////////////////////////

  // Raw syncs for the current raster position
  always_comb begin
    raw_sync.hsync = (phase_q == HP_SYNC);
    raw_sync.vsync = (line_q < vcnt_t'(V_SYNC));
    raw_sync.de    = (phase_q == HP_ACTIVE) &&
                     (line_q >= vcnt_t'(V_ACT_START)) &&
                     (line_q <  vcnt_t'(V_ACT_END));
  end

  // Match the converter latency so syncs and pixels stay paired
  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      for (int i = 0; i < PIX_LAT; i++) begin
        dly_q[i] <= '0;
      end
    end else begin
      dly_q[0] <= raw_sync;
      for (int i = 1; i < PIX_LAT; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  assign sync_o = dly_q[PIX_LAT-1];

endmodule

// ==== common/hdmi_out_pkg.sv ====
/*
 * HDMI output stage, shared definitions
 * Pixel and counter widths, the sync bundle that travels from the
 * raster generator to the output registers, the horizontal phase
 * encoding and the pixel path latency that both paths agree on
 */

package hdmi_out_pkg;

  //////////////////////////////
  // Pixel data
  //////////////////////////////

  // One 24 bit RGB pixel
  // Red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] pixel_t;

  // Single color channel
  typedef logic [7:0] color_t;

  //////////////////////////////
  // Raster counters
  //////////////////////////////

  // Horizontal count, wide enough for any phase length up to 4095
  typedef logic [11:0] hcnt_t;

  // Vertical line count, up to 2047 lines per frame
  typedef logic [10:0] vcnt_t;

  //////////////////////////////
  // Sync bundle
  //////////////////////////////

  // Active high syncs plus data enable
  // Bit order hsync, vsync, de from MSB down
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } sync_t;

  // Horizontal phases in line order
  // Counting up from HP_SYNC wraps back after HP_FRONT
  typedef enum logic [1:0] {
    HP_SYNC   = 2'd0,
    HP_BACK   = 2'd1,
    HP_ACTIVE = 2'd2,
    HP_FRONT  = 2'd3
  } hphase_e;

  //////////////////////////////
  // Pipeline alignment
  //////////////////////////////

  // Clocks through the color range converter
  // Sync path is delayed by the same amount
  localparam int PIX_LAT = 2;

endpackage
